//--- logic/mems_pkg.sv
package mems_pkg;

  // Clock plan
  localparam int SYS_CLK_HZ  = 64_000_000;
  localparam int FCLK_HZ     = 16_000;
  localparam int FCLK_DIV    = SYS_CLK_HZ / FCLK_HZ;
  localparam int MEMS_SPI_HZ = 3_200_000;
  localparam int SPI_HALF    = SYS_CLK_HZ / (2 * MEMS_SPI_HZ);

  localparam int NUM_CH      = 2;
  localparam int MEMS_WORD_W = 24;

  // Scan geometry
  localparam int ROM_DEPTH = 16;
  localparam int ADDR_W    = 4;
  localparam int LINE_LEN  = 4;
  localparam int FRAME_LEN = 16;

  typedef logic [MEMS_WORD_W-1:0] mems_word_t;
  typedef logic [ADDR_W-1:0]      mems_addr_t;

  // One channel's MEMS SPI pins
  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } mems_spi_pins_t;

endpackage

//--- logic/clk_divider.sv
`timescale 1ns/10ps

module clk_divider #(
  parameter int DIV = 4000
) (
  input  logic clk,
  input  logic rst_n,
  output logic clk_out
);

  localparam int HALF  = DIV / 2;
  localparam int CNT_W = $clog2(HALF + 1);

  logic [CNT_W-1:0] cnt;

  // Toggle once per half period, output starts low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      clk_out <= 1'b0;
    end else if (cnt == CNT_W'(HALF - 1)) begin
      cnt     <= '0;
      clk_out <= ~clk_out;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- logic/mems_pattern_rom.sv
`timescale 1ns/10ps

module mems_pattern_rom (
  input  logic                                      clk,
  input  mems_pkg::mems_addr_t [mems_pkg::NUM_CH-1:0] addr,
  output mems_pkg::mems_word_t [mems_pkg::NUM_CH-1:0] data
);
  import mems_pkg::*;

  mems_word_t mem [ROM_DEPTH];

  // Path is relative to the simulation run directory
  initial begin
    $readmemh("logic/mems_pattern.hex", mem);
  end

  // One registered read port per channel
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      data[i] <= mem[addr[i]];
    end
  end

endmodule

//--- logic/mems_scan_ctrl.sv
`timescale 1ns/10ps

module mems_scan_ctrl #(
  parameter int START_ADDR = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 scan_en,
  input  logic                 pause,
  input  logic                 busy,
  output mems_pkg::mems_addr_t rom_addr,
  input  mems_pkg::mems_word_t rom_data,
  output logic                 start,
  output mems_pkg::mems_word_t word,
  output logic                 new_line,
  output logic                 new_frame
);
  import mems_pkg::*;

  localparam int         LINE_W     = $clog2(LINE_LEN);
  localparam int         FRAME_W    = $clog2(FRAME_LEN);
  localparam mems_addr_t FIRST_ADDR = mems_addr_t'(START_ADDR);
  localparam mems_addr_t LAST_ADDR  = mems_addr_t'(ROM_DEPTH - 1);

  typedef enum logic [1:0] {IDLE, FETCH, SEND, WAIT} state_t;

  state_t             state;
  logic [LINE_W-1:0]  line_cnt;
  logic [FRAME_W-1:0] frame_cnt;
  logic               word_done;

  // Busy rises one cycle after start, so ignore the start cycle
  assign word_done = (state == WAIT) && !busy && !start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      rom_addr  <= FIRST_ADDR;
      line_cnt  <= '0;
      frame_cnt <= '0;
      start     <= 1'b0;
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      start     <= 1'b0;
      new_line  <= 1'b0;
      new_frame <= 1'b0;
      case (state)
        IDLE: begin
          // Disabled channel rewinds to its start
          if (!scan_en) begin
            rom_addr  <= FIRST_ADDR;
            line_cnt  <= '0;
            frame_cnt <= '0;
          end else if (!pause) begin
            state <= FETCH;
          end
        end
        // ROM read in flight
        FETCH: state <= SEND;
        SEND: begin
          start <= 1'b1;
          state <= WAIT;
        end
        WAIT: begin
          if (word_done) begin
            rom_addr <= (rom_addr == LAST_ADDR) ? '0 : rom_addr + 1'b1;
            if (line_cnt == LINE_W'(LINE_LEN - 1)) begin
              line_cnt <= '0;
              new_line <= 1'b1;
            end else begin
              line_cnt <= line_cnt + 1'b1;
            end
            if (frame_cnt == FRAME_W'(FRAME_LEN - 1)) begin
              frame_cnt <= '0;
              new_frame <= 1'b1;
            end else begin
              frame_cnt <= frame_cnt + 1'b1;
            end
            state <= (scan_en && !pause) ? FETCH : IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word is captured alongside the start pulse
  always_ff @(posedge clk) begin
    if (state == SEND) begin
      word <= rom_data;
    end
  end

endmodule

//--- logic/mems_spi.sv
`timescale 1ns/10ps

module mems_spi (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  mems_pkg::mems_word_t     word,
  output logic                     busy,
  output mems_pkg::mems_spi_pins_t pins
);
  import mems_pkg::*;

  localparam int HALF_W = $clog2(SPI_HALF + 1);
  localparam int BIT_W  = $clog2(MEMS_WORD_W);

  logic [HALF_W-1:0] half_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic              sck;
  logic              last;
  logic              half_done;
  logic              fall;
  mems_word_t        shreg;

  assign half_done = (half_cnt == HALF_W'(SPI_HALF - 1));

  // Falling sck edge, where mosi moves to the next bit
  assign fall = busy && !last && half_done && sck;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      sck      <= 1'b0;
      last     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      // A start while busy is dropped
      if (start) begin
        busy     <= 1'b1;
        half_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (last) begin
      // Release cs_n one cycle after the final fall
      busy <= 1'b0;
      last <= 1'b0;
    end else if (half_done) begin
      half_cnt <= '0;
      sck      <= ~sck;
      if (sck) begin
        if (bit_cnt == BIT_W'(MEMS_WORD_W - 1)) begin
          last <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shreg <= word;
    end else if (fall) begin
      shreg <= shreg << 1;
    end
  end

  // Chip select follows busy exactly, mosi idles low
  assign pins = '{
    sck:  sck,
    mosi: busy & shreg[MEMS_WORD_W-1],
    cs_n: ~busy
  };

endmodule

//--- logic/mems_scan_top.sv
`timescale 1ns/10ps

module mems_scan_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mems_pkg::NUM_CH-1:0]                   scan_en,
  input  logic                                          pause,
  output logic                                          fclk,
  output mems_pkg::mems_spi_pins_t [mems_pkg::NUM_CH-1:0] mems_spi,
  output logic [mems_pkg::NUM_CH-1:0]                   new_line,
  output logic [mems_pkg::NUM_CH-1:0]                   new_frame
);
  import mems_pkg::*;

  mems_addr_t [NUM_CH-1:0] rom_addr;
  mems_word_t [NUM_CH-1:0] rom_data;
  mems_word_t [NUM_CH-1:0] spi_word;
  logic       [NUM_CH-1:0] spi_start;
  logic       [NUM_CH-1:0] spi_busy;

  // Filter clock shared by every mirror
  clk_divider #(.DIV(FCLK_DIV)) fclk_div (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_out (fclk)
  );

  mems_pattern_rom pattern_rom (
    .clk  (clk),
    .addr (rom_addr),
    .data (rom_data)
  );

  for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
    // Channels start half a pattern apart
    mems_scan_ctrl #(.START_ADDR(k * 8)) scan_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .scan_en   (scan_en[k]),
      .pause     (pause),
      .busy      (spi_busy[k]),
      .rom_addr  (rom_addr[k]),
      .rom_data  (rom_data[k]),
      .start     (spi_start[k]),
      .word      (spi_word[k]),
      .new_line  (new_line[k]),
      .new_frame (new_frame[k])
    );

    mems_spi spi_master (
      .clk   (clk),
      .rst_n (rst_n),
      .start (spi_start[k]),
      .word  (spi_word[k]),
      .busy  (spi_busy[k]),
      .pins  (mems_spi[k])
    );
  end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- tb/mems_scan_tb.sv
`timescale 1ns/10ps

module mems_scan_tb;
  import mems_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_ROWS   = 8;
  localparam int WORD_CYC   = 48 * SPI_HALF + 10;
  localparam int PAUSE_CYC  = 1500;
  localparam int DELAY_MAX  = 1000;
  localparam int DWELL_CYC  = 3 * WORD_CYC;

  typedef struct packed {
    logic [NUM_CH-1:0] scan_en;
    logic              pause;
    logic [7:0]        words;
    logic              pulse;
  } row_t;

  // scan_en, pause level, words per enabled channel, pause pulse
  row_t rows [NUM_ROWS] = '{
    '{2'b11, 1'b0, 8'd20, 1'b0},
    '{2'b11, 1'b0, 8'd6,  1'b1},
    '{2'b11, 1'b1, 8'd0,  1'b0},
    '{2'b11, 1'b0, 8'd5,  1'b0},
    '{2'b10, 1'b0, 8'd5,  1'b0},
    '{2'b11, 1'b0, 8'd6,  1'b0},
    '{2'b01, 1'b0, 8'd4,  1'b0},
    '{2'b11, 1'b0, 8'd4,  1'b0}
  };

  logic                        clk;
  logic                        rst_n;
  logic [NUM_CH-1:0]           scan_en;
  logic                        pause;
  logic                        fclk;
  mems_spi_pins_t [NUM_CH-1:0] mems_spi;
  logic [NUM_CH-1:0]           new_line;
  logic [NUM_CH-1:0]           new_frame;

  // Capture and reference model per channel
  mems_spi_pins_t prev_pins [NUM_CH];
  mems_word_t     shift_reg [NUM_CH];
  mems_addr_t     model_addr [NUM_CH];
  int             bit_cnt [NUM_CH];
  int             scan_cnt [NUM_CH];
  int             done_cnt [NUM_CH];
  int             row_base [NUM_CH];
  logic           line_due [NUM_CH];
  logic           frame_due [NUM_CH];
  logic           hold [NUM_CH];
  logic           stopped [NUM_CH];

  int     value_errs;
  int     other_errs;
  int     fclk_cycles;
  int     fclk_next;
  int     fclk_toggles;
  logic   fclk_prev;
  integer seed;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_gen (.clk(clk));

  mems_scan_top mems_scan_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .scan_en   (scan_en),
    .pause     (pause),
    .fclk      (fclk),
    .mems_spi  (mems_spi),
    .new_line  (new_line),
    .new_frame (new_frame)
  );

  // Word at address a is a 3 followed by a five times
  function automatic mems_word_t pattern_word(input mems_addr_t a);
    return {4'h3, {5{a}}};
  endfunction

  task automatic clear_model(input int ch);
    model_addr[ch] = mems_addr_t'(ch * 8);
    scan_cnt[ch]   = 0;
    line_due[ch]   = 1'b0;
    frame_due[ch]  = 1'b0;
  endtask

  task automatic check_idle_outputs();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      assert ({mems_spi[ch].cs_n, mems_spi[ch].sck} === 2'b10) else begin
        value_errs++;
        $display("Fail mems_spi[%0d] {cs_n,sck}: got 0x%0h expected 0x2", ch,
                 {mems_spi[ch].cs_n, mems_spi[ch].sck});
      end
    end
    assert ({fclk, new_line, new_frame} === '0) else begin
      value_errs++;
      $display("Fail {fclk,new_line,new_frame}: got 0x%0h expected 0x0",
               {fclk, new_line, new_frame});
    end
  endtask

  // Sampled on the falling clock edge away from DUT updates
  task automatic track_channel(input int ch);
    mems_spi_pins_t cur;
    mems_word_t     exp_word;
    cur = mems_spi[ch];
    if (!pause) hold[ch] = 1'b0;
    // Pulses are due only on the cycle right after a word ends
    assert (new_line[ch] === line_due[ch]) else begin
      value_errs++;
      $display("Fail new_line[%0d]: got 0x%0h expected 0x%0h", ch,
               new_line[ch], line_due[ch]);
    end
    assert (new_frame[ch] === frame_due[ch]) else begin
      value_errs++;
      $display("Fail new_frame[%0d]: got 0x%0h expected 0x%0h", ch,
               new_frame[ch], frame_due[ch]);
    end
    line_due[ch]  = 1'b0;
    frame_due[ch] = 1'b0;
    if (prev_pins[ch].cs_n && !cur.cs_n) begin
      shift_reg[ch] = '0;
      bit_cnt[ch]   = 0;
      assert (!hold[ch] && !stopped[ch]) else begin
        other_errs++;
        $display("Channel %0d started a word while paused or disabled", ch);
      end
    end
    if (!prev_pins[ch].sck && cur.sck) begin
      shift_reg[ch] = {shift_reg[ch][MEMS_WORD_W-2:0], cur.mosi};
      bit_cnt[ch]++;
    end
    if (!prev_pins[ch].cs_n && cur.cs_n) begin
      exp_word = pattern_word(model_addr[ch]);
      assert (bit_cnt[ch] == MEMS_WORD_W) else begin
        other_errs++;
        $display("Channel %0d sent %0d clock pulses in one word", ch, bit_cnt[ch]);
      end
      assert (shift_reg[ch] == exp_word) else begin
        value_errs++;
        $display("Fail mems_spi[%0d] word: got 0x%06h expected 0x%06h", ch,
                 shift_reg[ch], exp_word);
      end
      model_addr[ch] = model_addr[ch] + 1'b1;
      scan_cnt[ch]++;
      done_cnt[ch]++;
      line_due[ch]  = (scan_cnt[ch] % LINE_LEN == 0);
      frame_due[ch] = (scan_cnt[ch] % FRAME_LEN == 0);
      hold[ch]      = pause;
    end
    prev_pins[ch] = cur;
  endtask

  task automatic wait_words(input logic [NUM_CH-1:0] en, input int n);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = 1'b1;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (en[ch] && done_cnt[ch] - row_base[ch] < n) done = 1'b0;
      end
    end
  endtask

  // Let the word in flight finish and then rewind the model
  task automatic stop_channel(input int ch);
    repeat (6) @(negedge clk);
    while (!mems_spi[ch].cs_n) @(negedge clk);
    repeat (2) @(negedge clk);
    clear_model(ch);
    stopped[ch] = 1'b1;
  endtask

  task automatic pause_pulse();
    int delay;
    delay = $unsigned($random(seed)) % DELAY_MAX;
    repeat (delay + 1) @(posedge clk);
    pause <= 1'b1;
    repeat (PAUSE_CYC) @(posedge clk);
    pause <= 1'b0;
  endtask

  always @(negedge clk) begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      track_channel(ch);
    end
  end

  // fclk edges counted in cycles from reset release
  always @(negedge clk) begin
    if (!rst_n) begin
      fclk_cycles  = 0;
      fclk_next    = FCLK_DIV / 2;
      fclk_toggles = 0;
      fclk_prev    = 1'b0;
    end else begin
      if (fclk !== fclk_prev) begin
        assert (fclk_cycles == fclk_next) else begin
          value_errs++;
          $display("Fail fclk toggle cycle: got 0x%0h expected 0x%0h", fclk_cycles, fclk_next);
        end
        fclk_next = fclk_cycles + FCLK_DIV / 2;
        fclk_toggles++;
      end
      fclk_prev = fclk;
      fclk_cycles++;
    end
  end

  initial begin
    int limit_cycles;
    limit_cycles = 100;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit_cycles += rows[r].words * WORD_CYC + DELAY_MAX + PAUSE_CYC + DWELL_CYC;
    end
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: run went past %0d clock cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [NUM_CH-1:0] prev_en;
    seed       = 32'he6049363;
    rst_n      = 1'b0;
    scan_en    = '0;
    pause      = 1'b0;
    prev_en    = '0;
    value_errs = 0;
    other_errs = 0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      prev_pins[ch] = '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1};
      shift_reg[ch] = '0;
      bit_cnt[ch]   = 0;
      done_cnt[ch]  = 0;
      hold[ch]      = 1'b0;
      stopped[ch]   = 1'b0;
      clear_model(ch);
    end
    repeat (10) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs();

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      scan_en <= rows[r].scan_en;
      pause   <= rows[r].pause;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        row_base[ch] = done_cnt[ch];
        if (rows[r].scan_en[ch]) stopped[ch] = 1'b0;
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (prev_en[ch] && !rows[r].scan_en[ch]) stop_channel(ch);
      end
      if (rows[r].pulse) begin
        fork
          pause_pulse();
          wait_words(rows[r].scan_en, rows[r].words);
        join
      end else if (rows[r].words == 0) begin
        repeat (DWELL_CYC) @(posedge clk);
      end else begin
        wait_words(rows[r].scan_en, rows[r].words);
      end
      prev_en = rows[r].scan_en;
    end

    repeat (3) @(negedge clk);
    assert (fclk_toggles >= 2) else begin
      other_errs++;
      $display("fclk toggled only %0d times during the run", fclk_toggles);
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- project.f
logic/mems_pkg.sv
logic/clk_divider.sv
logic/mems_pattern_rom.sv
logic/mems_scan_ctrl.sv
logic/mems_spi.sv
logic/mems_scan_top.sv
tb/tb_clock.sv
tb/mems_scan_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MEMS scan testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mems_scan_tb -f project.f \
  && ./obj_dir/Vmems_scan_tb 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -qF "*** TEST FAILED ***" sim.log \
  && { echo "Result: fail"; exit 1; } \
  || { echo "Result: pass"; exit 0; }

//--- logic/mems_pattern.hex
// One 24-bit scan word per line, addresses 0 to 15
300000
311111
322222
333333
344444
355555
366666
377777
388888
399999
3aaaaa
3bbbbb
3ccccc
3ddddd
3eeeee
3fffff
